// File: all.f
hw/waveGenPkg.sv
hw/waveIfs.sv
hw/phaseStepper.sv
hw/quadrantMapper.sv
hw/quarterWaveRom.sv
hw/signApplier.sv
hw/sinCosGenerator.sv
tests/tbClock.sv
tests/sinCosGen_assert.sv
tests/sinCosTb.sv

// File: Makefile
# Verilator build and run for the sine and cosine generator

VERILATOR  ?= verilator
TOP        ?= sinCosTb
RTL_TOP    ?= sinCosGenerator
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
SIM_BIN    ?= V$(TOP)
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_TEXT  ?= RESULT: PASS

RTL_FILES ?= hw/waveGenPkg.sv \
	hw/waveIfs.sv \
	hw/phaseStepper.sv \
	hw/quadrantMapper.sv \
	hw/quarterWaveRom.sv \
	hw/signApplier.sv \
	hw/sinCosGenerator.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(SIM_BIN)

run: build
	@out="$$(./$(BUILD_DIR)/$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR)

// File: tests/sinCosTb.sv
/* Testbench for the quadrature sine and cosine generator
   Own phase model and table, output checks by concurrent assertions */
`timescale 1ns/1ps

module sinCosTb;
	import waveGenPkg::*;

	// ====================
	// Run constants
	// ====================
	localparam int RESET_CYCLES   = 10;
	localparam int LATENCY        = 4;                // Enabled edge to o_valid
	localparam int PERIOD         = 1 << PHASE_WIDTH; // Samples per wave at step 1
	localparam int RANDOM_CYCLES  = 3000;
	localparam int TIMEOUT_CYCLES = 12000;            // Tests need about 8400 cycles

	logic                           clock;
	logic                           reset;
	logic                           enable;
	logic [STEP_WIDTH-1:0]          stepExp;
	logic signed [SAMPLE_WIDTH-1:0] sinSample;
	logic signed [SAMPLE_WIDTH-1:0] cosSample;
	logic                           sampleValid;

	int   refTable [TABLE_DEPTH]; // Quarter-wave magnitudes
	int   modelPhase = 0;
	int   expSinQ [$];            // Pairs still in flight
	int   expCosQ [$];
	int   expSin;                 // Pair due at the next edge
	int   expCos;
	logic expKnown = 1'b0;
	logic [LATENCY-1:0] enableHistory = '0; // Oldest enable in the top bit
	int   outOfReset = 0;         // Saturating count of clean edges since reset
	int   cycleCount = 0;
	int   failCount = 0;
	int   testsPassed = 0;
	int   testsFailed = 0;
	int   failuresAtStart;

	tbClock tbClock_i (
		.o_clock (clock)
	);

	sinCosGenerator sinCosGenerator_i (
		.i_clock   (clock),
		.i_reset   (reset),
		.i_enable  (enable),
		.i_stepExp (stepExp),
		.o_sin     (sinSample),
		.o_cos     (cosSample),
		.o_valid   (sampleValid)
	);

	// ====================
	// Reference model
	// ====================
	function automatic void buildTable();
		real pi;
		real angle;
		pi = 4.0 * $atan(1.0);
		for (int i = 0; i < TABLE_DEPTH; i++) begin
			angle       = (i + 0.5) * pi / 512.0; // Half step into each entry
			refTable[i] = int'(AMPLITUDE * $sin(angle)); // Nearest integer
		end
	endfunction

	function automatic void expectedPair(input int phase, output int sinVal, output int cosVal);
		int quadrant;
		int idx;
		int mirror;
		quadrant = phase / TABLE_DEPTH;
		idx      = phase % TABLE_DEPTH;
		mirror   = TABLE_DEPTH - 1 - idx;
		case (quadrant)
			0: begin
				sinVal = refTable[idx];
				cosVal = refTable[mirror];
			end
			1: begin
				sinVal = refTable[mirror];
				cosVal = -refTable[idx];
			end
			2: begin
				sinVal = -refTable[idx];
				cosVal = -refTable[mirror];
			end
			default: begin
				sinVal = -refTable[mirror];
				cosVal = refTable[idx];
			end
		endcase
	endfunction

	// One pair per enabled edge
	always @(posedge clock) begin : referenceModel
		int sinVal;
		int cosVal;
		if (reset) begin
			modelPhase = 0; // Pipeline is flushed too
			expSinQ.delete();
			expCosQ.delete();
		end else if (enable) begin
			expectedPair(modelPhase, sinVal, cosVal);
			expSinQ.push_back(sinVal);
			expCosQ.push_back(cosVal);
			modelPhase = (modelPhase + (1 << stepExp)) % PERIOD;
		end
	end

	// Pop where the outputs are stable
	always @(negedge clock) begin
		if (sampleValid) begin
			if (expSinQ.size() > 0) begin
				expSin   = expSinQ.pop_front();
				expCos   = expCosQ.pop_front();
				expKnown = 1'b1;
			end else begin
				expKnown = 1'b0; // Output nobody asked for
			end
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			outOfReset <= 0;
		end else if (outOfReset < LATENCY) begin
			outOfReset <= outOfReset + 1;
		end
	end

	always @(posedge clock) begin
		enableHistory <= {enableHistory[LATENCY-2:0], enable};
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles, %0d samples never came out",
				cycleCount, expSinQ.size());
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// ====================
	// Checks
	// ====================
	function automatic void reportMismatch(input string signalName, input int expected,
		input int actual);
		failCount++;
		$display("MISMATCH time %0t %s expected %0d actual %0d",
			$time, signalName, expected, actual);
	endfunction

	function automatic void reportFailure(input string what);
		failCount++;
		$display("Check failed at time %0t: %s", $time, what);
	endfunction

	sampleExpected: assert property (@(posedge clock) disable iff (reset)
		sampleValid |-> expKnown)
		else reportFailure("o_valid rose with no sample expected by the model");

	sinMatch: assert property (@(posedge clock) disable iff (reset)
		(sampleValid && expKnown) |-> (int'(sinSample) == expSin))
		else reportMismatch("o_sin", expSin, int'($sampled(sinSample)));

	cosMatch: assert property (@(posedge clock) disable iff (reset)
		(sampleValid && expKnown) |-> (int'(cosSample) == expCos))
		else reportMismatch("o_cos", expCos, int'($sampled(cosSample)));

	validLatency: assert property (@(posedge clock) disable iff (reset)
		(outOfReset >= LATENCY) |-> (sampleValid == enableHistory[LATENCY-1]))
		else reportMismatch("o_valid", int'($sampled(enableHistory[LATENCY-1])),
			int'($sampled(sampleValid)));

	// ====================
	// Test helpers
	// ====================
	function automatic int totalFailures();
		return failCount + sinCosGenerator_i.sinCosGen_assert_i.violations;
	endfunction

	task automatic startTest();
		failuresAtStart = totalFailures();
	endtask

	task automatic finishTest(input int number, input string name);
		if (totalFailures() == failuresAtStart) begin
			testsPassed++;
			$display("Test %0d %s: passed", number, name);
		end else begin
			testsFailed++;
			$display("Test %0d %s: failed, %0d check failures", number, name,
				totalFailures() - failuresAtStart);
		end
	endtask

	task automatic runCycles(input int count);
		repeat (count) @(negedge clock);
	endtask

	// Waits until every expected pair has come out
	task automatic drainPipeline();
		enable = 1'b0;
		while (expSinQ.size() != 0) begin
			@(negedge clock);
		end
		@(negedge clock); // Lets the last popped pair be compared
	endtask

	task automatic applyReset(input int cycles);
		reset = 1'b1;
		runCycles(cycles);
		reset = 1'b0;
	endtask

	// ====================
	// Stimulus
	// ====================
	initial begin : stimulus
		void'($urandom(32'h51c4));
		reset   = 1'b1;
		enable  = 1'b0;
		stepExp = '0;
		buildTable();

		startTest();
		applyReset(RESET_CYCLES);
		runCycles(6); // Outputs sit at zero while idle
		enable = 1'b1;
		runCycles(1);
		drainPipeline();
		finishTest(1, "reset state and first sample");

		startTest();
		stepExp = '0;
		enable  = 1'b1;
		runCycles(PERIOD + LATENCY); // All four quadrants
		drainPipeline();
		finishTest(2, "full period at step 1");

		startTest();
		enable = 1'b1;
		for (int k = 0; k < 8; k++) begin
			stepExp = STEP_WIDTH'(k);
			runCycles(2 * (PERIOD >> k)); // Two periods per exponent
		end
		drainPipeline();
		finishTest(3, "step exponent sweep");

		startTest();
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			enable = 1'($urandom_range(1, 0));
			if ($urandom_range(7, 0) == 0) begin
				stepExp = STEP_WIDTH'($urandom_range(7, 0));
			end
			runCycles(1);
		end
		drainPipeline();
		finishTest(4, "random enable and step");

		startTest();
		stepExp = 3'd3;
		enable  = 1'b1;
		runCycles(37);
		applyReset(3); // Samples in flight are dropped while enable stays high
		runCycles(20);
		drainPipeline();
		finishTest(5, "reset mid-run");

		$display("Tests passed %0d, failed %0d, check failures %0d",
			testsPassed, testsFailed, totalFailures());
		if (testsFailed == 0 && totalFailures() == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: tests/sinCosGen_assert.sv
/* Output protocol checks for the wave generator
   Watches o_valid around reset, output hold and sample range */
`timescale 1ns/1ps

module sinCosGen_assert (
	input logic                                       i_clock,
	input logic                                       i_reset,
	input logic                                       i_valid,
	input logic signed [waveGenPkg::SAMPLE_WIDTH-1:0] i_sin,
	input logic signed [waveGenPkg::SAMPLE_WIDTH-1:0] i_cos
);
	import waveGenPkg::*;

	int violations = 0; // Count of failed checks

	// ====================
	// Reset
	// ====================
	validLowAfterReset: assert property (@(posedge i_clock)
		($past(i_reset) || $past(i_reset, 2)) |-> !i_valid)
		else begin
			violations++;
			$error("o_valid high during reset or in the cycle after it");
		end

	// Both samples start from zero
	zeroAfterReset: assert property (@(posedge i_clock)
		$past(i_reset) |-> (i_sin == '0 && i_cos == '0))
		else begin
			violations++;
			$error("o_sin or o_cos not cleared by reset");
		end

	// ====================
	// Hold and range
	// ====================
	holdWhileIdle: assert property (@(posedge i_clock) disable iff (i_reset)
		(!i_valid && !$past(i_reset)) |-> ($stable(i_sin) && $stable(i_cos)))
		else begin
			violations++;
			$error("o_sin or o_cos changed while o_valid was low");
		end

	sampleInRange: assert property (@(posedge i_clock) disable iff (i_reset)
		(int'(i_sin) >= -AMPLITUDE && int'(i_sin) <= AMPLITUDE &&
		 int'(i_cos) >= -AMPLITUDE && int'(i_cos) <= AMPLITUDE))
		else begin
			violations++;
			$error("o_sin or o_cos outside the table amplitude");
		end

endmodule

bind sinCosGenerator sinCosGen_assert sinCosGen_assert_i (
	.i_clock (i_clock),
	.i_reset (i_reset),
	.i_valid (o_valid),
	.i_sin   (o_sin),
	.i_cos   (o_cos)
);

// File: tests/tbClock.sv
/* Testbench clock
   Free-running clock with a 4 ns period */
`timescale 1ns/1ps

module tbClock (
	output logic o_clock
);
	localparam int HALF_PERIOD = 2; // ns, gives a 4 ns period

	initial begin
		o_clock = 1'b0; // Known level before the first edge
	end

	always begin
		#HALF_PERIOD o_clock = ~o_clock;
	end

endmodule

// File: hw/sinCosGenerator.sv
/* Quadrature sine and cosine generator
   Four-stage pipeline from phase accumulator to signed samples */
`timescale 1ns/1ps

module sinCosGenerator (
	input  logic                                       i_clock,
	input  logic                                       i_reset,
	input  logic                                       i_enable,  // One sample per enabled clock
	input  logic        [waveGenPkg::STEP_WIDTH-1:0]   i_stepExp, // Phase step exponent
	output logic signed [waveGenPkg::SAMPLE_WIDTH-1:0] o_sin,
	output logic signed [waveGenPkg::SAMPLE_WIDTH-1:0] o_cos,
	output logic                                       o_valid    // 4 cycles after enable
);
	import waveGenPkg::*;

	phaseWord_u phase;      // Stepper to mapper
	logic       phaseValid;

	romReqIf romReq ();      // Mapper to table
	sampleIf sampleLink ();  // Table to sign stage

	// ====================
	// Input side
	// ====================
	phaseStepper phaseStepper_i (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_enable     (i_enable),
		.i_stepExp    (i_stepExp),
		.o_phase      (phase),
		.o_phaseValid (phaseValid)
	);

	// ====================
	// Processing
	// ====================
	quadrantMapper quadrantMapper_i (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_phase      (phase),
		.i_phaseValid (phaseValid),
		.romReq       (romReq.source)
	);

	quarterWaveRom quarterWaveRom_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.romReq  (romReq.sink),
		.sample  (sampleLink.source)
	);

	// ====================
	// Output side
	// ====================
	signApplier signApplier_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.sample  (sampleLink.sink),
		.o_sin   (o_sin),
		.o_cos   (o_cos),
		.o_valid (o_valid)
	);

endmodule

// File: hw/signApplier.sv
/* Sign applier
   Negates the table magnitudes where needed and holds the output samples */
`timescale 1ns/1ps

module signApplier (
	input  logic                                       i_clock,
	input  logic                                       i_reset,
	sampleIf.sink                                      sample,
	output logic signed [waveGenPkg::SAMPLE_WIDTH-1:0] o_sin,
	output logic signed [waveGenPkg::SAMPLE_WIDTH-1:0] o_cos,
	output logic                                       o_valid
);
	import waveGenPkg::*;

	logic signed [SAMPLE_WIDTH-1:0] sinSigned; // Magnitude with sign applied
	logic signed [SAMPLE_WIDTH-1:0] cosSigned;

	// Magnitude never exceeds 127, so negation cannot overflow
	assign sinSigned = sample.sinNeg ? -$signed(sample.sinMag) : $signed(sample.sinMag);
	assign cosSigned = sample.cosNeg ? -$signed(sample.cosMag) : $signed(sample.cosMag);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_sin   <= '0;
			o_cos   <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= sample.valid; // One-cycle strobe per sample
			if (sample.valid) begin
				o_sin <= sinSigned; // Hold last value otherwise
				o_cos <= cosSigned;
			end
		end
	end

endmodule

// File: hw/quarterWaveRom.sv
/* Quarter-wave sine table
   Two registered read ports, filled at elaboration from the sine function */
`timescale 1ns/1ps

module quarterWaveRom (
	input  logic    i_clock,
	input  logic    i_reset,
	romReqIf.sink   romReq,
	sampleIf.source sample
);
	import waveGenPkg::*;

	logic [SAMPLE_WIDTH-1:0] sineTable [TABLE_DEPTH]; // Magnitudes 0..AMPLITUDE

	// ====================
	// Table fill
	// ====================
	// Entry i is sampled half a step in, so the table reads the same
	// backwards as a cosine quarter
	initial begin : fillTable
		real angle;
		real value;

		for (int i = 0; i < TABLE_DEPTH; i++) begin
			angle        = (real'(i) + 0.5) * PI / real'(2 * TABLE_DEPTH);
			value        = real'(AMPLITUDE) * $sin(angle);
			sineTable[i] = SAMPLE_WIDTH'($rtoi(value + 0.5)); // Round, always positive
		end
	end

	// ====================
	// Read ports
	// ====================
	// Both ports read in the same cycle
	always_ff @(posedge i_clock) begin
		sample.sinMag <= sineTable[romReq.sinAddr];
		sample.cosMag <= sineTable[romReq.cosAddr];
		sample.sinNeg <= romReq.sinNeg; // Flags delayed to match the read
		sample.cosNeg <= romReq.cosNeg;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sample.valid <= 1'b0;
		end else begin
			sample.valid <= romReq.valid;
		end
	end

endmodule

// File: hw/quadrantMapper.sv
/* Quadrant mapper
   Turns the phase into sine and cosine table addresses with their negate flags */
`timescale 1ns/1ps

module quadrantMapper (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  waveGenPkg::phaseWord_u i_phase,
	input  logic                   i_phaseValid,
	romReqIf.source                romReq
);
	import waveGenPkg::*;

	logic [PHASE_WIDTH-INDEX_WIDTH-1:0] quadrant;
	logic [INDEX_WIDTH-1:0]             index;
	logic [INDEX_WIDTH-1:0]             mirrorIndex; // 255 - index
	logic [INDEX_WIDTH-1:0]             sinAddrNext;
	logic [INDEX_WIDTH-1:0]             cosAddrNext;
	logic                               sinNegNext;
	logic                               cosNegNext;

	assign quadrant    = i_phase.fields.quadrant;
	assign index       = i_phase.fields.index;
	assign mirrorIndex = ~index; // Half-step table makes this exact

	// ====================
	// Quadrant rule
	// ====================
	// Odd quadrants run the sine backwards through the table,
	// the cosine does the opposite
	always_comb begin
		sinAddrNext = quadrant[0] ? mirrorIndex : index;
		cosAddrNext = quadrant[0] ? index : mirrorIndex;
		sinNegNext  = quadrant[1];               // Quadrants 2 and 3
		cosNegNext  = quadrant[1] ^ quadrant[0]; // Quadrants 1 and 2
	end

	// Payload registers, no reset
	always_ff @(posedge i_clock) begin
		romReq.sinAddr <= sinAddrNext;
		romReq.cosAddr <= cosAddrNext;
		romReq.sinNeg  <= sinNegNext;
		romReq.cosNeg  <= cosNegNext;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			romReq.valid <= 1'b0;
		end else begin
			romReq.valid <= i_phaseValid; // Strobe follows the data
		end
	end

endmodule

// File: hw/phaseStepper.sv
/* Phase stepper
   Accumulates the phase by a power-of-two step on each enabled clock */
`timescale 1ns/1ps

module phaseStepper (
	input  logic                              i_clock,
	input  logic                              i_reset,
	input  logic                              i_enable,     // Advance and emit one sample
	input  logic [waveGenPkg::STEP_WIDTH-1:0] i_stepExp,    // Step is 2**i_stepExp
	output waveGenPkg::phaseWord_u            o_phase,      // Phase of the emitted sample
	output logic                              o_phaseValid
);
	import waveGenPkg::*;

	phaseWord_u             phaseAcc; // Phase of the next sample
	logic [PHASE_WIDTH-1:0] stepInc;  // Single set bit

	// Period is 1024 >> i_stepExp samples
	assign stepInc = {{(PHASE_WIDTH-1){1'b0}}, 1'b1} << i_stepExp;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			phaseAcc.raw <= '0;     // First sample after reset is phase 0
			o_phase.raw  <= '0;
			o_phaseValid <= 1'b0;
		end else begin
			o_phaseValid <= i_enable; // One cycle latency from the enable edge
			if (i_enable) begin
				o_phase      <= phaseAcc;               // Present the current phase
				phaseAcc.raw <= phaseAcc.raw + stepInc; // Wraps modulo 1024
			end
		end
	end

endmodule

// File: hw/waveIfs.sv
/* Pipeline links of the wave generator
   Table read request and table result with sign flags */
`timescale 1ns/1ps

interface romReqIf;
	import waveGenPkg::*;

	logic [INDEX_WIDTH-1:0] sinAddr; // Table address for sine
	logic [INDEX_WIDTH-1:0] cosAddr; // Mirrored or direct address for cosine
	logic                   sinNeg;  // Sine lies in the lower half
	logic                   cosNeg;  // Cosine lies in the lower half
	logic                   valid;   // One strobe per sample

	modport source (output sinAddr, cosAddr, sinNeg, cosNeg, valid);
	modport sink   (input  sinAddr, cosAddr, sinNeg, cosNeg, valid);
endinterface

interface sampleIf;
	import waveGenPkg::*;

	logic [SAMPLE_WIDTH-1:0] sinMag; // Unsigned table value for sine
	logic [SAMPLE_WIDTH-1:0] cosMag; // Unsigned table value for cosine
	logic                    sinNeg; // Travels with sinMag
	logic                    cosNeg; // Travels with cosMag
	logic                    valid;

	modport source (output sinMag, cosMag, sinNeg, cosNeg, valid);
	modport sink   (input  sinMag, cosMag, sinNeg, cosNeg, valid);
endinterface

// File: hw/waveGenPkg.sv
/* Wave generator package
   Shared sizes, table constants and the phase word seen as count or as quadrant/index */
package waveGenPkg;

	// ====================
	// Sizes
	// ====================
	localparam int PHASE_WIDTH  = 10;             // Full phase word
	localparam int INDEX_WIDTH  = 8;              // Quarter-wave table address
	localparam int TABLE_DEPTH  = 256;            // Entries per quarter wave
	localparam int SAMPLE_WIDTH = 8;              // Signed output sample
	localparam int STEP_WIDTH   = 3;              // Step exponent, 0 to 7

	// ====================
	// Table constants
	// ====================
	localparam int  AMPLITUDE = 127;              // Peak table value
	localparam real PI        = 3.14159265358979; // For the elaboration-time table fill

	// Quadrant sits above the index in the phase word
	typedef struct packed {
		logic [PHASE_WIDTH-INDEX_WIDTH-1:0] quadrant; // Quarter of the period
		logic [INDEX_WIDTH-1:0]             index;    // Position inside the quarter
	} phaseFields_s;

	// One phase word, two readings
	typedef union packed {
		logic [PHASE_WIDTH-1:0] raw;    // Plain count for the accumulator
		phaseFields_s           fields; // Decoded view for the mapper
	} phaseWord_u;

endpackage
